//--- pcs_pkg.sv
// 64b/66b block layer types; clause 49 control blocks only, ordered-set contents are not decoded
package pcs_pkg;

    localparam int DATA_W = 64;
    localparam int HDR_W = 2;
    localparam int KEEP_W = DATA_W / 8;

    localparam logic [HDR_W-1:0] SYNC_DATA = 2'b10;
    localparam logic [HDR_W-1:0] SYNC_CTRL = 2'b01;

    // block type byte sits in bits 7:0 of a control block
    localparam logic [7:0] BLOCK_TYPE_CTRL = 8'h1e;
    localparam logic [7:0] BLOCK_TYPE_OS_4 = 8'h2d;
    localparam logic [7:0] BLOCK_TYPE_START_4 = 8'h33;
    localparam logic [7:0] BLOCK_TYPE_OS_START = 8'h66;
    localparam logic [7:0] BLOCK_TYPE_OS_04 = 8'h55;
    localparam logic [7:0] BLOCK_TYPE_START_0 = 8'h78;
    localparam logic [7:0] BLOCK_TYPE_OS_0 = 8'h4b;
    // terminates, n data bytes ahead of /T/
    localparam logic [7:0] BLOCK_TYPE_TERM_0 = 8'h87;
    localparam logic [7:0] BLOCK_TYPE_TERM_1 = 8'h99;
    localparam logic [7:0] BLOCK_TYPE_TERM_2 = 8'haa;
    localparam logic [7:0] BLOCK_TYPE_TERM_3 = 8'hb4;
    localparam logic [7:0] BLOCK_TYPE_TERM_4 = 8'hcc;
    localparam logic [7:0] BLOCK_TYPE_TERM_5 = 8'hd2;
    localparam logic [7:0] BLOCK_TYPE_TERM_6 = 8'he1;
    localparam logic [7:0] BLOCK_TYPE_TERM_7 = 8'hff;

    // top bit marks a terminate, low three bits count its data bytes
    typedef enum logic [3:0] {
        IDLE    = 4'd0,
        ERROR   = 4'd1,
        START_0 = 4'd2,
        START_4 = 4'd3,
        DATA    = 4'd4,
        TERM_0  = 4'd8,
        TERM_1  = 4'd9,
        TERM_2  = 4'd10,
        TERM_3  = 4'd11,
        TERM_4  = 4'd12,
        TERM_5  = 4'd13,
        TERM_6  = 4'd14,
        TERM_7  = 4'd15
    } input_type_e;

    // word aligned to lane 0, bytes after a terminate are zero
    typedef struct packed {
        logic [DATA_W-1:0] data;
        input_type_e       itype;
    } decoded_block_t;

endpackage

//--- eth_rx_pkg.sv
// receive-side MAC types; the frame stream carries no tid, tdest or tstrb and user is one error bit
package eth_rx_pkg;

    // reflected CRC-32 and the register left after a good FCS, no final inversion
    localparam logic [31:0] CRC_POLY = 32'hedb88320;
    localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

    typedef struct packed {
        logic [pcs_pkg::DATA_W-1:0] data;
        logic [pcs_pkg::KEEP_W-1:0] keep;
        logic                       valid;
        logic                       last;
        logic                       user;
    } rx_beat_t;

    // one-cycle pulses
    typedef struct packed {
        logic [1:0] start_packet;
        logic       error_bad_frame;
        logic       error_bad_fcs;
        logic       rx_bad_block;
        logic       rx_sequence_error;
    } rx_status_t;

    // bit k: residue seen after byte k of the current word
    typedef logic [pcs_pkg::KEEP_W-1:0] crc_match_t;

    typedef enum logic [1:0] {
        STATE_IDLE    = 2'd0,
        STATE_PAYLOAD = 2'd1,
        STATE_LAST    = 2'd2
    } framer_state_e;

endpackage

//--- baser_block_decoder.sv
// one block per clock; a start in lane 4 shifts all later words by half a block until a lane-0 start
`timescale 1ns/10ps

module baser_block_decoder (
    input  logic                        clk,
    input  logic                        reset_crc,
    input  logic [pcs_pkg::DATA_W-1:0]  encoded_rx_data,
    input  logic [pcs_pkg::HDR_W-1:0]   encoded_rx_hdr,
    output pcs_pkg::decoded_block_t     decoded,
    output logic [1:0]                  start_packet,
    output logic                        rx_bad_block
);
    import pcs_pkg::*;

    logic [DATA_W-1:0] data_masked;
    logic              is_data;
    logic              is_ctrl;
    logic              is_term;
    logic              is_start_0;
    logic              is_start_4;
    logic              idle_ctrl;
    logic              block_bad;
    logic [2:0]        term_n;
    input_type_e       aligned_type;
    input_type_e       swapped_type;
    input_type_e       delay_type_next;
    input_type_e       delay_type;
    logic              delay_type_valid;
    logic              lanes_swapped;
    logic [31:0]       swap_data;

    assign is_data = encoded_rx_hdr == SYNC_DATA;
    assign is_ctrl = encoded_rx_hdr == SYNC_CTRL;
    assign is_term = is_ctrl && encoded_rx_data[7];
    assign term_n = encoded_rx_data[6:4];
    assign is_start_0 = is_ctrl && encoded_rx_data[7:0] == BLOCK_TYPE_START_0;
    assign is_start_4 = is_ctrl && encoded_rx_data[7:0] inside {BLOCK_TYPE_START_4,
                                                                BLOCK_TYPE_OS_START};
    assign idle_ctrl = encoded_rx_data[7:4] inside {BLOCK_TYPE_CTRL[7:4], BLOCK_TYPE_OS_4[7:4],
                                                    BLOCK_TYPE_OS_04[7:4], BLOCK_TYPE_OS_0[7:4]};

    // full type byte check, the datapath only looks at the high nibble
    assign block_bad = !is_data && !(is_ctrl && encoded_rx_data[7:0] inside {
        BLOCK_TYPE_CTRL, BLOCK_TYPE_OS_4, BLOCK_TYPE_START_4, BLOCK_TYPE_OS_START,
        BLOCK_TYPE_OS_04, BLOCK_TYPE_START_0, BLOCK_TYPE_OS_0, BLOCK_TYPE_TERM_0,
        BLOCK_TYPE_TERM_1, BLOCK_TYPE_TERM_2, BLOCK_TYPE_TERM_3, BLOCK_TYPE_TERM_4,
        BLOCK_TYPE_TERM_5, BLOCK_TYPE_TERM_6, BLOCK_TYPE_TERM_7});

    // drop the type byte of a terminate and clear everything from /T/ up
    assign data_masked = is_term ?
        (encoded_rx_data >> 8) & ~({DATA_W{1'b1}} << (8 * term_n)) : encoded_rx_data;

    always_comb begin
        aligned_type = ERROR;
        swapped_type = ERROR;
        delay_type_next = ERROR;
        if (is_data) begin
            aligned_type = DATA;
            swapped_type = DATA;
        end else if (is_term) begin
            aligned_type = input_type_e'({1'b1, term_n});
            // upper half terminates land in the next word
            swapped_type = term_n[2] ? DATA : input_type_e'({2'b11, term_n[1:0]});
            delay_type_next = input_type_e'({1'b1, ~term_n[2], term_n[1:0]});
        end else if (is_ctrl && idle_ctrl) begin
            aligned_type = IDLE;
            swapped_type = IDLE;
        end else if (is_start_0) begin
            aligned_type = START_0;
        end else if (is_start_4) begin
            delay_type_next = START_0;
        end
    end

    always_ff @(posedge clk) begin
        rx_bad_block <= block_bad;
        start_packet <= 2'b00;
        delay_type_valid <= 1'b0;
        delay_type <= delay_type_next;
        swap_data <= data_masked[63:32];

        if (is_start_0) begin
            lanes_swapped <= 1'b0;
            decoded.itype <= START_0;
            decoded.data <= data_masked;
        end else if (is_start_4) begin
            lanes_swapped <= 1'b1;
            delay_type_valid <= 1'b1;
            decoded.itype <= delay_type_valid ? delay_type : IDLE;
            decoded.data <= {data_masked[31:0], swap_data};
        end else if (lanes_swapped) begin
            if (delay_type_valid) begin
                decoded.itype <= delay_type;
                decoded.data <= {32'd0, swap_data};
            end else begin
                decoded.itype <= swapped_type;
                decoded.data <= {data_masked[31:0], swap_data};
                delay_type_valid <= is_term && term_n[2];
            end
        end else begin
            decoded.itype <= aligned_type;
            decoded.data <= data_masked;
        end

        if (block_bad) begin
            decoded.itype <= ERROR;
        end

        if (delay_type_valid && delay_type == START_0) begin
            start_packet <= 2'b10;
        end
        if (decoded.itype == START_0 && !lanes_swapped) begin
            start_packet <= 2'b01;
        end

        if (reset_crc) begin
            decoded.itype <= IDLE;
            start_packet <= 2'b00;
            rx_bad_block <= 1'b0;
            lanes_swapped <= 1'b0;
            delay_type_valid <= 1'b0;
            delay_type <= IDLE;
        end
    end

    // lane-4 starts must reach the framer realigned as lane-0 starts
    assert property (@(posedge clk) disable iff (reset_crc)
        $past(is_start_4 && !reset_crc) && !block_bad |=> decoded.itype == START_0);

endmodule

//--- baser_seq_checker.sv
// checks block order on the raw stream only; bad sync headers leave the frame state alone
`timescale 1ns/10ps

module baser_seq_checker (
    input  logic                        clk,
    input  logic                        reset_crc,
    input  logic [pcs_pkg::HDR_W-1:0]   encoded_rx_hdr,
    input  logic [pcs_pkg::DATA_W-1:0]  encoded_rx_data,
    output logic                        rx_sequence_error
);
    import pcs_pkg::*;

    logic       in_frame;
    logic [3:0] type_hi;

    assign type_hi = encoded_rx_data[7:4];

    always_ff @(posedge clk) begin
        rx_sequence_error <= 1'b0;
        if (encoded_rx_hdr == SYNC_DATA) begin
            rx_sequence_error <= !in_frame;
        end else if (encoded_rx_hdr == SYNC_CTRL) begin
            in_frame <= 1'b0;
            if (type_hi inside {BLOCK_TYPE_START_0[7:4], BLOCK_TYPE_START_4[7:4],
                                BLOCK_TYPE_OS_START[7:4]}) begin
                in_frame <= 1'b1;
                rx_sequence_error <= in_frame;
            end else if (type_hi inside {BLOCK_TYPE_CTRL[7:4], BLOCK_TYPE_OS_4[7:4],
                                         BLOCK_TYPE_OS_04[7:4], BLOCK_TYPE_OS_0[7:4]}) begin
                rx_sequence_error <= in_frame;
            end else if (encoded_rx_data[7]) begin
                // terminate
                rx_sequence_error <= !in_frame;
            end
        end

        if (reset_crc) begin
            in_frame <= 1'b0;
            rx_sequence_error <= 1'b0;
        end
    end

endmodule

//--- eth_crc_checker.sv
// CRC-32 over whole decoded words; a partial last word is judged by the per-byte match bits
`timescale 1ns/10ps

module eth_crc_checker (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  pcs_pkg::decoded_block_t  decoded,
    input  logic                     crc_restart,
    output eth_rx_pkg::crc_match_t   crc_match,
    output eth_rx_pkg::crc_match_t   crc_match_prev
);
    import pcs_pkg::*;
    import eth_rx_pkg::*;

    logic [31:0] crc_state;
    logic [31:0] crc_full;

    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] din);
        logic [31:0] c;
        c = crc ^ {24'd0, din};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? (c >> 1) ^ CRC_POLY : c >> 1;
        end
        return c;
    endfunction

    // byte 0 first, residue compared after every byte
    always_comb begin
        logic [31:0] crc_run;
        crc_run = crc_state;
        for (int k = 0; k < KEEP_W; k++) begin
            crc_run = crc_byte(crc_run, decoded.data[8*k +: 8]);
            crc_match[k] = crc_run == CRC_RESIDUE;
        end
        crc_full = crc_run;
    end

    always_ff @(posedge clk) begin
        crc_match_prev <= crc_match;
        if (reset_crc || crc_restart) begin
            crc_state <= '1;
        end else begin
            crc_state <= crc_full;
        end
        if (reset_crc) begin
            crc_match_prev <= '0;
        end
    end

endmodule

//--- baser_rx_framer.sv
// no back-pressure, beats leave as they form; preamble, SFD and FCS are stripped from the stream
`timescale 1ns/10ps

module baser_rx_framer (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  logic                     cfg_rx_enable,
    input  pcs_pkg::decoded_block_t  decoded,
    input  eth_rx_pkg::crc_match_t   crc_match,
    input  eth_rx_pkg::crc_match_t   crc_match_prev,
    output logic                     crc_restart,
    output eth_rx_pkg::rx_beat_t     rx_beat,
    output logic                     error_bad_frame,
    output logic                     error_bad_fcs
);
    import pcs_pkg::*;
    import eth_rx_pkg::*;

    framer_state_e  state;
    framer_state_e  state_next;
    decoded_block_t d1;
    rx_beat_t       beat_next;
    logic           bad_frame_next;
    logic           bad_fcs_next;
    logic           fcs_ok;
    logic [2:0]     term_n;

    assign term_n = decoded.itype[2:0];

    always_comb begin
        state_next = state;
        crc_restart = 1'b0;
        beat_next = '{data: d1.data, keep: '0, valid: 1'b0, last: 1'b0, user: 1'b0};
        bad_frame_next = 1'b0;
        bad_fcs_next = 1'b0;
        fcs_ok = 1'b0;

        case (state)
            STATE_IDLE: begin
                crc_restart = 1'b1;
                if (d1.itype == START_0 && cfg_rx_enable) begin
                    crc_restart = 1'b0;
                    state_next = STATE_PAYLOAD;
                end
            end
            STATE_PAYLOAD: begin
                beat_next.keep = '1;
                beat_next.valid = 1'b1;
                if (decoded.itype[3]) begin
                    crc_restart = 1'b1;
                    if (term_n <= 3'd4) begin
                        // last four bytes of the frame are FCS
                        beat_next.keep = ~({KEEP_W{1'b1}} << (4 + term_n));
                        beat_next.last = 1'b1;
                        fcs_ok = term_n == 3'd0 ? crc_match_prev[KEEP_W-1] :
                                                  crc_match[term_n - 3'd1];
                        beat_next.user = !fcs_ok;
                        bad_frame_next = !fcs_ok;
                        bad_fcs_next = !fcs_ok;
                        state_next = STATE_IDLE;
                    end else begin
                        state_next = STATE_LAST;
                    end
                end else if (decoded.itype != DATA) begin
                    // control or error inside the frame
                    beat_next.last = 1'b1;
                    beat_next.user = 1'b1;
                    bad_frame_next = 1'b1;
                    crc_restart = 1'b1;
                    state_next = STATE_IDLE;
                end
            end
            STATE_LAST: begin
                crc_restart = 1'b1;
                beat_next.keep = ~({KEEP_W{1'b1}} << d1.itype[1:0]);
                beat_next.valid = 1'b1;
                beat_next.last = 1'b1;
                fcs_ok = crc_match_prev[d1.itype[2:0] - 3'd1];
                beat_next.user = !fcs_ok;
                bad_frame_next = !fcs_ok;
                bad_fcs_next = !fcs_ok;
                state_next = STATE_IDLE;
            end
            default: begin
                state_next = STATE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        state <= state_next;
        d1 <= decoded;
        rx_beat <= beat_next;
        error_bad_frame <= bad_frame_next;
        error_bad_fcs <= bad_fcs_next;
        if (reset_crc) begin
            state <= STATE_IDLE;
            d1.itype <= IDLE;
            rx_beat.valid <= 1'b0;
            rx_beat.last <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (reset_crc) rx_beat.valid |-> rx_beat.keep != '0);
    assert property (@(posedge clk) disable iff (reset_crc) rx_beat.last |-> rx_beat.valid);

endmodule

//--- baser_rx_64.sv
// 10GBASE-R receive for a 64-bit datapath; every clock must carry a block and output is never held
`timescale 1ns/10ps

module baser_rx_64 (
    input  logic                        clk,
    input  logic                        reset_crc,
    input  logic [pcs_pkg::DATA_W-1:0]  encoded_rx_data,
    input  logic [pcs_pkg::HDR_W-1:0]   encoded_rx_hdr,
    input  logic                        cfg_rx_enable,
    output eth_rx_pkg::rx_beat_t        rx_beat,
    output eth_rx_pkg::rx_status_t      rx_status
);
    import pcs_pkg::*;
    import eth_rx_pkg::*;

    decoded_block_t decoded;
    crc_match_t     crc_match;
    crc_match_t     crc_match_prev;
    logic           crc_restart;
    logic [1:0]     start_packet;
    logic           rx_bad_block;
    logic           rx_sequence_error;
    logic           error_bad_frame;
    logic           error_bad_fcs;

    baser_block_decoder u_baser_block_decoder (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .encoded_rx_data (encoded_rx_data),
        .encoded_rx_hdr  (encoded_rx_hdr),
        .decoded         (decoded),
        .start_packet    (start_packet),
        .rx_bad_block    (rx_bad_block)
    );

    baser_seq_checker u_baser_seq_checker (
        .clk               (clk),
        .reset_crc         (reset_crc),
        .encoded_rx_hdr    (encoded_rx_hdr),
        .encoded_rx_data   (encoded_rx_data),
        .rx_sequence_error (rx_sequence_error)
    );

    eth_crc_checker u_eth_crc_checker (
        .clk            (clk),
        .reset_crc      (reset_crc),
        .decoded        (decoded),
        .crc_restart    (crc_restart),
        .crc_match      (crc_match),
        .crc_match_prev (crc_match_prev)
    );

    baser_rx_framer u_baser_rx_framer (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .cfg_rx_enable   (cfg_rx_enable),
        .decoded         (decoded),
        .crc_match       (crc_match),
        .crc_match_prev  (crc_match_prev),
        .crc_restart     (crc_restart),
        .rx_beat         (rx_beat),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs)
    );

    assign rx_status = '{
        start_packet:      start_packet,
        error_bad_frame:   error_bad_frame,
        error_bad_fcs:     error_bad_fcs,
        rx_bad_block:      rx_bad_block,
        rx_sequence_error: rx_sequence_error
    };

endmodule

//--- tb_clock_gen.sv
// free-running clock from time zero; reset_crc drops 1 ns after the last reset edge
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset_crc
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset_crc = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_crc = 1'b0;
    end

endmodule

//--- tb_baser_rx_64.sv
// directed tests; beats and status pulses are sampled on the falling clock edge
`timescale 1ns/10ps

module tb_baser_rx_64;
    import pcs_pkg::*;
    import eth_rx_pkg::*;

    logic              clk;
    logic              reset_crc;
    logic [DATA_W-1:0] encoded_rx_data;
    logic [HDR_W-1:0]  encoded_rx_hdr;
    logic              cfg_rx_enable;
    rx_beat_t          rx_beat;
    rx_status_t        rx_status;

    logic [7:0] frame_q[$];
    logic [7:0] out_q[$];
    rx_beat_t   beat_q[$];
    rx_status_t seen;
    int         start_cnt;
    int         bad_block_cnt;
    int         seq_cnt;
    int         bad_frame_cnt;
    int         bad_fcs_cnt;
    int         errors;
    int         test_errors;
    int         tests;
    int         failed_tests;

    tb_clock_gen u_tb_clock_gen (.clk(clk), .reset_crc(reset_crc));

    baser_rx_64 u_baser_rx_64 (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .encoded_rx_data (encoded_rx_data),
        .encoded_rx_hdr  (encoded_rx_hdr),
        .cfg_rx_enable   (cfg_rx_enable),
        .rx_beat         (rx_beat),
        .rx_status       (rx_status)
    );

    always @(negedge clk) begin
        if (rx_beat.valid) begin
            beat_q.push_back(rx_beat);
        end
        seen = rx_status_t'(seen | rx_status);
        if (rx_status.start_packet != 2'b00) begin
            start_cnt++;
        end
        if (rx_status.rx_bad_block) begin
            bad_block_cnt++;
        end
        if (rx_status.rx_sequence_error) begin
            seq_cnt++;
        end
        if (rx_status.error_bad_frame) begin
            bad_frame_cnt++;
        end
        if (rx_status.error_bad_fcs) begin
            bad_fcs_cnt++;
        end
    end

    function automatic logic [31:0] crc_bitwise(input logic [31:0] crc, input logic [7:0] din);
        logic fb;
        for (int b = 0; b < 8; b++) begin
            fb = crc[0] ^ din[b];
            crc = crc >> 1;
            if (fb) begin
                crc = crc ^ 32'hedb88320;
            end
        end
        return crc;
    endfunction

    function automatic logic [7:0] term_type(input int n);
        case (n)
            0: return BLOCK_TYPE_TERM_0;
            1: return BLOCK_TYPE_TERM_1;
            2: return BLOCK_TYPE_TERM_2;
            3: return BLOCK_TYPE_TERM_3;
            4: return BLOCK_TYPE_TERM_4;
            5: return BLOCK_TYPE_TERM_5;
            6: return BLOCK_TYPE_TERM_6;
            default: return BLOCK_TYPE_TERM_7;
        endcase
    endfunction

    // preamble, SFD, payload, FCS low byte first; flip >= 0 corrupts one payload byte
    task automatic build_frame(input int len, input int flip);
        logic [31:0] crc;
        frame_q = {};
        crc = '1;
        repeat (7) frame_q.push_back(8'h55);
        frame_q.push_back(8'hd5);
        for (int i = 0; i < len; i++) begin
            frame_q.push_back(8'($urandom));
            crc = crc_bitwise(crc, frame_q[8 + i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            frame_q.push_back(crc[8*i +: 8]);
        end
        if (flip >= 0) begin
            frame_q[8 + flip] = frame_q[8 + flip] ^ 8'h01;
        end
        out_q = frame_q[8 : 8 + len - 1];
    endtask

    task automatic send_block(input logic [HDR_W-1:0] hdr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        #1;
        encoded_rx_hdr = hdr;
        encoded_rx_data = data;
    endtask

    task automatic send_idle();
        send_block(SYNC_CTRL, {56'd0, BLOCK_TYPE_CTRL});
    endtask

    // cut >= 0 stops after that many data blocks and sends idles in place of the rest
    task automatic send_frame(input bit lane4, input int cut);
        logic [DATA_W-1:0] blk;
        int                idx;
        int                nblk;
        blk = '0;
        if (lane4) begin
            blk[7:0] = BLOCK_TYPE_START_4;
            for (int i = 1; i < 4; i++) begin
                blk[8*(4+i) +: 8] = frame_q[i];
            end
            idx = 4;
        end else begin
            blk[7:0] = BLOCK_TYPE_START_0;
            for (int i = 1; i < 8; i++) begin
                blk[8*i +: 8] = frame_q[i];
            end
            idx = 8;
        end
        send_block(SYNC_CTRL, blk);
        nblk = 0;
        while (frame_q.size() - idx >= 8 && nblk != cut) begin
            for (int i = 0; i < 8; i++) begin
                blk[8*i +: 8] = frame_q[idx + i];
            end
            send_block(SYNC_DATA, blk);
            idx += 8;
            nblk++;
        end
        if (nblk != cut) begin
            blk = '0;
            blk[7:0] = term_type(frame_q.size() - idx);
            for (int i = 0; i < frame_q.size() - idx; i++) begin
                blk[8*(i+1) +: 8] = frame_q[idx + i];
            end
            send_block(SYNC_CTRL, blk);
        end
        repeat (4) send_idle();
    endtask

    task automatic check_beat(input string name, input rx_beat_t exp, input rx_beat_t act);
        for (int i = 0; i < KEEP_W; i++) begin
            if (!act.keep[i]) begin
                act.data[8*i +: 8] = 8'h00;
            end
        end
        if (act !== exp) begin
            $display("[ERROR] %s beat: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_status(input string name, input rx_status_t exp, input rx_status_t act);
        if (act !== exp) begin
            $display("[ERROR] %s status: expected %b, actual %b", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic wait_last(input string name);
        int cycles;
        cycles = 0;
        while (!(beat_q.size() > 0 && beat_q[beat_q.size()-1].last) && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= 200) begin
            $display("%s: no beat with last arrived before the timeout", name);
            test_errors++;
        end
    endtask

    task automatic check_frame(input string name, input logic user);
        rx_beat_t exp;
        int       nbeats;
        nbeats = (out_q.size() + 7) / 8;
        check_count({name, " beat count"}, nbeats, beat_q.size());
        for (int b = 0; b < nbeats && b < beat_q.size(); b++) begin
            exp = '0;
            for (int i = 0; i < 8 && 8*b + i < out_q.size(); i++) begin
                exp.data[8*i +: 8] = out_q[8*b + i];
                exp.keep[i] = 1'b1;
            end
            exp.valid = 1'b1;
            exp.last = b == nbeats - 1;
            exp.user = exp.last && user;
            check_beat(name, exp, beat_q[b]);
        end
    endtask

    task automatic start_test();
        beat_q = {};
        seen = '0;
        start_cnt = 0;
        bad_block_cnt = 0;
        seq_cnt = 0;
        bad_frame_cnt = 0;
        bad_fcs_cnt = 0;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        tests++;
        errors += test_errors;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %s: %s", name, test_errors == 0 ? "ok" : "FAIL");
    endtask

    task automatic good_frame(input bit lane4, input int len);
        string name;
        name = $sformatf("%s_len%0d", lane4 ? "lane4" : "lane0", len);
        start_test();
        build_frame(len, -1);
        send_frame(lane4, -1);
        wait_last(name);
        check_frame(name, 1'b0);
        check_status(name, '{lane4 ? 2'b10 : 2'b01, 1'b0, 1'b0, 1'b0, 1'b0}, seen);
        check_count({name, " start pulses"}, 1, start_cnt);
        end_test(name);
    endtask

    initial begin
        int cycles;
        void'($urandom(32'hce5d5979));
        encoded_rx_hdr = SYNC_CTRL;
        encoded_rx_data = {56'd0, BLOCK_TYPE_CTRL};
        cfg_rx_enable = 1'b1;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        start_test();
        cycles = 0;
        while (reset_crc !== 1'b0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (reset_crc !== 1'b0) begin
            $display("reset did not release before the timeout");
            errors++;
        end
        repeat (4) send_idle();

        for (int k = 0; k < 8; k++) begin
            good_frame(1'b0, 60 + k);
        end
        for (int k = 0; k < 8; k++) begin
            good_frame(1'b1, 60 + k);
        end

        start_test();
        build_frame(64, 10);
        send_frame(1'b0, -1);
        wait_last("bad_fcs");
        check_frame("bad_fcs", 1'b1);
        check_status("bad_fcs", '{2'b01, 1'b1, 1'b1, 1'b0, 1'b0}, seen);
        check_count("bad_fcs frame pulses", 1, bad_frame_cnt);
        check_count("bad_fcs fcs pulses", 1, bad_fcs_cnt);
        end_test("bad_fcs");

        // idle block after three data blocks
        start_test();
        build_frame(64, -1);
        out_q = frame_q[8 : 31];
        send_frame(1'b0, 3);
        wait_last("idle_in_frame");
        check_frame("idle_in_frame", 1'b1);
        check_status("idle_in_frame", '{2'b01, 1'b1, 1'b0, 1'b0, 1'b1}, seen);
        check_count("idle_in_frame sequence pulses", 1, seq_cnt);
        check_count("idle_in_frame frame pulses", 1, bad_frame_cnt);
        end_test("idle_in_frame");

        start_test();
        send_block(2'b00, 64'h0123_4567_89ab_cdef);
        repeat (2) send_idle();
        send_block(SYNC_CTRL, 64'h0);
        repeat (2) send_idle();
        send_block(SYNC_DATA, 64'hfeed_face_cafe_beef);
        repeat (4) send_idle();
        check_count("bad_blocks bad block pulses", 2, bad_block_cnt);
        check_count("bad_blocks sequence pulses", 1, seq_cnt);
        check_status("bad_blocks", '{2'b00, 1'b0, 1'b0, 1'b1, 1'b1}, seen);
        end_test("bad_blocks");

        start_test();
        cfg_rx_enable = 1'b0;
        build_frame(64, -1);
        send_frame(1'b0, -1);
        cycles = 0;
        while (beat_q.size() == 0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        check_count("rx_disabled beats", 0, beat_q.size());
        send_idle();
        cfg_rx_enable = 1'b1;
        beat_q = {};
        build_frame(65, -1);
        send_frame(1'b0, -1);
        wait_last("rx_enabled");
        check_frame("rx_enabled", 1'b0);
        end_test("rx_enable");

        $display("%0d tests run, %0d failing, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (20000) @(posedge clk);
        $display("simulation did not finish before the global timeout");
        $display("tests failed");
        $finish;
    end

endmodule

//--- baser_rx_64.f
pcs_pkg.sv
eth_rx_pkg.sv
baser_block_decoder.sv
baser_seq_checker.sv
eth_crc_checker.sv
baser_rx_framer.sv
baser_rx_64.sv
tb_clock_gen.sv
tb_baser_rx_64.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_baser_rx_64
FILELIST ?= baser_rx_64.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
